//--- verilog/slm_panel_pkg.sv
// =========================================================================
// shared definitions for the frame reader debug panel
// bus widths, capture depths, offset reset values,
// seven-segment glyph codes and the switch word union
// =========================================================================

`default_nettype none

package slm_panel_pkg;

    // ---- bus widths
    localparam int sw_width         = 10;
    localparam int offset_width     = 8;
    localparam int probe_width      = 19;
    // top sample bit is the valid mark
    localparam int sample_width     = 9;
    // status field sits above the sample in the probe word
    localparam int status_width     = 10;
    localparam int mem_addr_width   = 25;

    // ---- logic analyzer geometry
    localparam int history_depth    = 10;
    localparam int post_depth       = 5;
    localparam int slot_count       = 16;
    localparam int slot_index_width = 4;

    // ---- offset reset values, sign and magnitude
    // horizontal starts at -127
    localparam logic [offset_width-1:0] x_offset_reset = 8'd127;
    localparam logic                    x_sign_reset   = 1'b1;
    // vertical starts at +3
    localparam logic [offset_width-1:0] y_offset_reset = 8'd3;
    localparam logic                    y_sign_reset   = 1'b0;

    // =====================================================================
    // seven-segment glyphs, active low, segment g in bit 6
    // =====================================================================
    localparam logic [6:0] glyph_b     = 7'b0000011;
    localparam logic [6:0] glyph_u     = 7'b1000001;
    localparam logic [6:0] glyph_s     = 7'b0010010;
    localparam logic [6:0] glyph_y     = 7'b0010001;
    localparam logic [6:0] glyph_blank = 7'b1111111;

    // =====================================================================
    // switch word, read either as an offset load value or a slot pick
    // =====================================================================

    // offset view
    typedef struct packed {
        logic                    sign;
        // bit 8 carries nothing in this view
        logic                    spare;
        logic [offset_width-1:0] magnitude;
    } offset_view_t;

    // slot view, any upper bit set means the status display
    typedef struct packed {
        logic [sw_width-slot_index_width-1:0] upper;
        logic [slot_index_width-1:0]          index;
    } slot_view_t;

    typedef union packed {
        offset_view_t offset;
        slot_view_t   slot;
    } switch_word_u;

endpackage

`default_nettype wire

//--- verilog/offset_regs.sv
// =========================================================================
// horizontal and vertical image offset registers
// sign and magnitude, loaded from a shared value on per-axis enables
// =========================================================================

`default_nettype none

module offset_regs
    import slm_panel_pkg::*;
(
    input  wire                     CLOCK_50,
    input  wire                     delayed_reset,

    // per-axis load enables, one cycle wide
    input  wire                     load_x,
    input  wire                     load_y,

    // value shared by both axes
    input  wire [offset_width-1:0]  load_value,
    input  wire                     load_sign,

    output logic [offset_width-1:0] offset_x,
    output logic                    offset_x_sign,
    output logic [offset_width-1:0] offset_y,
    output logic                    offset_y_sign
);

    // =====================================================================
    // offset state
    // =====================================================================

    // each axis loads independently, both load if both enables are high
    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            offset_x      <= x_offset_reset;
            offset_x_sign <= x_sign_reset;
            offset_y      <= y_offset_reset;
            offset_y_sign <= y_sign_reset;
        end else begin
            // horizontal, + moves the image right
            if (load_x) begin
                offset_x      <= load_value;
                offset_x_sign <= load_sign;
            end
            // vertical, + moves the image down
            if (load_y) begin
                offset_y      <= load_value;
                offset_y_sign <= load_sign;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/trace_capture.sv
// =========================================================================
// small logic analyzer on the probe's low sample bits
// pre-trigger history shift register, post-trigger counter,
// sixteen capture slots and a combinational slot read port
// =========================================================================

`default_nettype none

module trace_capture
    import slm_panel_pkg::*;
(
    input  wire                         CLOCK_50,
    input  wire                         delayed_reset,

    // probe low bits, msb marks a trigger sample
    input  wire [sample_width-1:0]      sample,

    // read port
    input  wire [slot_index_width-1:0]  slot_index,
    output logic [sample_width-1:0]     slot_data
);

    // =====================================================================
    // storage
    // =====================================================================

    // index 0 holds the oldest sample
    logic [sample_width-1:0]     history [history_depth];

    // slots 0..9 pre-trigger, 10 trigger, 11..15 post-trigger
    logic [sample_width-1:0]     slots [slot_count];

    // zero is idle, 1..5 pick a post slot, then runs on to wrap
    logic [slot_index_width-1:0] post_cnt;

    logic                        trigger;
    logic                        post_write;

    assign trigger = sample[sample_width-1];

    // counts 1 through post_depth fill the post-trigger slots
    assign post_write = (post_cnt != '0) &&
                        (post_cnt <= slot_index_width'(post_depth));

    // =====================================================================
    // history shift, one step per clock
    // =====================================================================
    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            for (int i = 0; i < history_depth; i++) begin
                history[i] <= '0;
            end
        end else begin
            for (int i = 0; i < history_depth - 1; i++) begin
                history[i] <= history[i+1];
            end
            history[history_depth-1] <= sample;
        end
    end

    // =====================================================================
    // capture slots and post counter
    // =====================================================================
    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            post_cnt <= '0;
            for (int i = 0; i < slot_count; i++) begin
                slots[i] <= '0;
            end
        end else if (trigger) begin
            // new trigger restarts the window, even mid-capture
            post_cnt <= slot_index_width'(1);
            for (int i = 0; i < history_depth; i++) begin
                slots[i] <= history[i];
            end
            slots[history_depth] <= sample;
        end else begin
            // advance only while running, wraps to idle after 15
            if (post_cnt != '0) begin
                post_cnt <= post_cnt + 1'b1;
            end
            if (post_write) begin
                slots[history_depth + int'(post_cnt)] <= sample;
            end
        end
    end

    // =====================================================================
    // read port
    // =====================================================================

    // combinational, so a capture shows one cycle after its edge
    assign slot_data = slots[slot_index];

endmodule

`default_nettype wire

//--- verilog/panel_control.sv
// =========================================================================
// panel decode and selection
// switch word decode, LED source choice, busy glyphs on the digits,
// memory address choice and read gating during upload
// =========================================================================

`default_nettype none

module panel_control
    import slm_panel_pkg::*;
(
    // board controls
    input  wire [sw_width-1:0]          sw,
    input  wire                         update_x,
    input  wire                         update_y,

    // upload and reader side
    input  wire                         write_done,
    input  wire [mem_addr_width-1:0]    write_addr,
    input  wire [mem_addr_width-1:0]    read_addr,
    input  wire                         read_en,

    // debug sources
    input  wire [status_width-1:0]      probe_status,
    input  wire [sample_width-1:0]      slot_data,

    // to offset_regs
    output logic                        load_x,
    output logic                        load_y,
    output logic [offset_width-1:0]     load_value,
    output logic                        load_sign,

    // to trace_capture
    output logic [slot_index_width-1:0] slot_index,

    // board outputs
    output logic [status_width-1:0]     ledr,
    output logic [6:0]                  hex0,
    output logic [6:0]                  hex1,
    output logic [6:0]                  hex2,
    output logic [6:0]                  hex3,
    output logic [6:0]                  hex4,
    output logic [6:0]                  hex5,

    // memory port
    output logic [mem_addr_width-1:0]   mem_addr,
    output logic                        mem_read
);

    // =====================================================================
    // switch decode
    // =====================================================================
    switch_word_u sw_word;
    logic         status_view;

    assign sw_word = sw;

    // strobes go straight through as load enables
    assign load_x     = update_x;
    assign load_y     = update_y;
    assign load_value = sw_word.offset.magnitude;
    assign load_sign  = sw_word.offset.sign;

    assign slot_index = sw_word.slot.index;

    // switch word above 15
    assign status_view = (sw_word.slot.upper != '0);

    // =====================================================================
    // LED source
    // =====================================================================

    // slot sample zero-extended, or the probe status field
    assign ledr = status_view ? probe_status
                              : {{(status_width-sample_width){1'b0}}, slot_data};

    // =====================================================================
    // seven-segment digits
    // =====================================================================

    // "busy" on the upper four while the upload runs
    assign hex5 = write_done ? glyph_blank : glyph_b;
    assign hex4 = write_done ? glyph_blank : glyph_u;
    assign hex3 = write_done ? glyph_blank : glyph_s;
    assign hex2 = write_done ? glyph_blank : glyph_y;
    // lower two unused
    assign hex1 = glyph_blank;
    assign hex0 = glyph_blank;

    // =====================================================================
    // memory port
    // =====================================================================

    // writer owns the port until the upload is done
    assign mem_addr = write_done ? read_addr : write_addr;
    // reads held off during upload
    assign mem_read = read_en & write_done;

endmodule

`default_nettype wire

//--- verilog/slm_panel_top.sv
// =========================================================================
// frame reader debug and control panel, top level
// panel decode, offset registers and trace capture
// =========================================================================

`default_nettype none

module slm_panel_top
    import slm_panel_pkg::*;
(
    input  wire                         CLOCK_50,
    input  wire                         delayed_reset,

    input  wire [sw_width-1:0]          sw,
    input  wire                         update_x,
    input  wire                         update_y,
    input  wire [probe_width-1:0]       probe,

    input  wire                         write_done,
    input  wire [mem_addr_width-1:0]    write_addr,
    input  wire [mem_addr_width-1:0]    read_addr,
    input  wire                         read_en,

    output wire [status_width-1:0]      ledr,
    output wire [6:0]                   hex0,
    output wire [6:0]                   hex1,
    output wire [6:0]                   hex2,
    output wire [6:0]                   hex3,
    output wire [6:0]                   hex4,
    output wire [6:0]                   hex5,

    output wire [offset_width-1:0]      offset_x,
    output wire                         offset_x_sign,
    output wire [offset_width-1:0]      offset_y,
    output wire                         offset_y_sign,

    output wire [mem_addr_width-1:0]    mem_addr,
    output wire                         mem_read
);

    // offset load path
    wire                         load_x;
    wire                         load_y;
    wire [offset_width-1:0]      load_value;
    wire                         load_sign;

    // capture read path
    wire [slot_index_width-1:0]  slot_index;
    wire [sample_width-1:0]      slot_data;

    // =====================================================================
    // instances
    // =====================================================================
    panel_control u_panel_control (
        .sw           (sw),
        .update_x     (update_x),
        .update_y     (update_y),
        .write_done   (write_done),
        .write_addr   (write_addr),
        .read_addr    (read_addr),
        .read_en      (read_en),
        // status field above the sample bits
        .probe_status (probe[probe_width-1:sample_width]),
        .slot_data    (slot_data),
        .load_x       (load_x),
        .load_y       (load_y),
        .load_value   (load_value),
        .load_sign    (load_sign),
        .slot_index   (slot_index),
        .ledr         (ledr),
        .hex0         (hex0),
        .hex1         (hex1),
        .hex2         (hex2),
        .hex3         (hex3),
        .hex4         (hex4),
        .hex5         (hex5),
        .mem_addr     (mem_addr),
        .mem_read     (mem_read)
    );

    offset_regs u_offset_regs (
        .CLOCK_50      (CLOCK_50),
        .delayed_reset (delayed_reset),
        .load_x        (load_x),
        .load_y        (load_y),
        .load_value    (load_value),
        .load_sign     (load_sign),
        .offset_x      (offset_x),
        .offset_x_sign (offset_x_sign),
        .offset_y      (offset_y),
        .offset_y_sign (offset_y_sign)
    );

    trace_capture u_trace_capture (
        .CLOCK_50      (CLOCK_50),
        .delayed_reset (delayed_reset),
        .sample        (probe[sample_width-1:0]),
        .slot_index    (slot_index),
        .slot_data     (slot_data)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
// =========================================================================
// testbench clock, 20 unit period, and a two-cycle reset
// =========================================================================

`default_nettype none

module tb_clock_gen (
    output logic CLOCK_50,
    output logic delayed_reset
);

    localparam int clk_period = 20;

    initial begin
        CLOCK_50 = 1'b0;
        forever #(clk_period / 2) CLOCK_50 = ~CLOCK_50;
    end

    // released just after the second rising edge
    initial begin
        delayed_reset = 1'b1;
        repeat (2) @(posedge CLOCK_50);
        delayed_reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/slm_panel_chk.sv
// =========================================================================
// concurrent assertions on the panel top level, attached by bind
// blank low digits, read gating, offset hold, no unknown outputs
// =========================================================================

`default_nettype none

module slm_panel_chk
    import slm_panel_pkg::*;
(
    input wire                      CLOCK_50,
    input wire                      delayed_reset,
    input wire                      update_x,
    input wire                      write_done,
    input wire                      mem_read,
    input wire [mem_addr_width-1:0] mem_addr,
    input wire [status_width-1:0]   ledr,
    input wire [6:0]                hex0, hex1, hex2, hex3, hex4, hex5,
    input wire [offset_width-1:0]   offset_x, offset_y,
    input wire                      offset_x_sign, offset_y_sign
);

    // failed assertions, read by the testbench top
    int unsigned fail_count = 0;

    low_digits_blank: assert property (@(posedge CLOCK_50)
        (hex1 == glyph_blank) && (hex0 == glyph_blank))
        else begin fail_count++; $error("hex1 or hex0 is not blank"); end

    // no read request during the upload
    read_needs_done: assert property (@(posedge CLOCK_50) mem_read |-> write_done)
        else begin fail_count++; $error("mem_read high while write_done is low"); end

    x_holds_without_load: assert property (@(posedge CLOCK_50) disable iff (delayed_reset)
        !update_x |=> $stable({offset_x_sign, offset_x}))
        else begin fail_count++; $error("offset_x changed without a load"); end

    outputs_known: assert property (@(posedge CLOCK_50) disable iff (delayed_reset)
        !$isunknown({ledr, hex0, hex1, hex2, hex3, hex4, hex5, offset_x, offset_x_sign,
                     offset_y, offset_y_sign, mem_addr, mem_read}))
        else begin fail_count++; $error("an output is unknown after reset"); end

endmodule

bind slm_panel_top slm_panel_chk u_chk (.*);

`default_nettype wire

//--- dv/tb_panel_monitor.sv
// =========================================================================
// reference model of the panel and output comparison
// offsets, capture history, post counter, slots, LED and port rules
// =========================================================================

`default_nettype none

module tb_panel_monitor
    import slm_panel_pkg::*;
(
    input wire                      CLOCK_50,
    input wire                      delayed_reset,
    input wire [sw_width-1:0]       sw,
    input wire                      update_x, update_y,
    input wire [probe_width-1:0]    probe,
    input wire                      write_done, read_en,
    input wire [mem_addr_width-1:0] write_addr, read_addr, mem_addr,
    input wire                      mem_read,
    input wire [status_width-1:0]   ledr,
    input wire [6:0]                hex0, hex1, hex2, hex3, hex4, hex5,
    input wire [offset_width-1:0]   offset_x, offset_y,
    input wire                      offset_x_sign, offset_y_sign,
    output int unsigned             check_count,
    output int unsigned             error_count
);

    logic [sample_width-1:0] m_hist [history_depth];
    logic [sample_width-1:0] m_slots [slot_count];
    logic [sample_width-1:0] m_smp;
    logic [offset_width-1:0] m_off_x, m_off_y;
    logic                    m_sign_x, m_sign_y;
    logic [status_width-1:0] exp_led;
    int                      m_cnt;

    initial begin
        check_count = 0;
        error_count = 0;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // =====================================================================
    // model advances on the same edge as the DUT
    // =====================================================================
    always @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            // -127 and +3
            m_off_x  = 8'd127;
            m_sign_x = 1'b1;
            m_off_y  = 8'd3;
            m_sign_y = 1'b0;
            m_cnt    = 0;
            foreach (m_hist[i]) m_hist[i] = '0;
            foreach (m_slots[i]) m_slots[i] = '0;
        end else begin
            m_smp = probe[sample_width-1:0];
            // valid mark copies the pre-trigger history oldest first, then the trigger
            if (m_smp[sample_width-1]) begin
                for (int i = 0; i < 10; i++) m_slots[i] = m_hist[i];
                m_slots[10] = m_smp;
                m_cnt = 1;
            end else if (m_cnt != 0) begin
                if (m_cnt <= 5) m_slots[10 + m_cnt] = m_smp;
                // idle again once past 15
                m_cnt = (m_cnt + 1) % 16;
            end
            for (int i = 0; i < 9; i++) m_hist[i] = m_hist[i+1];
            m_hist[9] = m_smp;
            if (update_x) {m_sign_x, m_off_x} = {sw[9], sw[7:0]};
            if (update_y) {m_sign_y, m_off_y} = {sw[9], sw[7:0]};
        end
    end

    // =====================================================================
    // compare mid-cycle once inputs and outputs have settled
    // =====================================================================
    always @(negedge CLOCK_50) begin
        if (!delayed_reset) begin
            check_value("offset_x", {m_sign_x, m_off_x}, {offset_x_sign, offset_x});
            check_value("offset_y", {m_sign_y, m_off_y}, {offset_y_sign, offset_y});
            // status field above 15, slot sample otherwise
            exp_led = (sw > 15) ? probe[18:9] : {1'b0, m_slots[sw[3:0]]};
            check_value("ledr", exp_led, ledr);
            check_value("hex5", write_done ? 7'h7f : 7'b0000011, hex5);
            check_value("hex4", write_done ? 7'h7f : 7'b1000001, hex4);
            check_value("hex3", write_done ? 7'h7f : 7'b0010010, hex3);
            check_value("hex2", write_done ? 7'h7f : 7'b0010001, hex2);
            check_value("hex1", 7'h7f, hex1);
            check_value("hex0", 7'h7f, hex0);
            check_value("mem_addr", write_done ? read_addr : write_addr, mem_addr);
            check_value("mem_read", read_en && write_done, mem_read);
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_slm_panel.sv
// =========================================================================
// testbench top with clock, DUT, monitor, seeded random stimulus, watchdog
// =========================================================================

`default_nettype none

module tb_slm_panel
    import slm_panel_pkg::*;
();

    localparam int clk_period     = 20;
    localparam int offset_cycles  = 200;
    localparam int capture_cycles = 600;
    localparam int status_cycles  = 200;
    localparam int port_cycles    = 200;
    localparam int total_cycles   = offset_cycles + capture_cycles + status_cycles + port_cycles;

    wire                       CLOCK_50, delayed_reset;
    logic [sw_width-1:0]       sw;
    logic                      update_x, update_y, write_done, read_en;
    logic [probe_width-1:0]    probe;
    logic [mem_addr_width-1:0] write_addr, read_addr;
    wire [mem_addr_width-1:0]  mem_addr;
    wire                       mem_read, offset_x_sign, offset_y_sign;
    wire [status_width-1:0]    ledr;
    wire [6:0]                 hex0, hex1, hex2, hex3, hex4, hex5;
    wire [offset_width-1:0]    offset_x, offset_y;
    int unsigned               check_count, error_count;
    integer                    seed = 53;

    tb_clock_gen u_clock_gen (.CLOCK_50(CLOCK_50), .delayed_reset(delayed_reset));

    slm_panel_top dut (.*);

    tb_panel_monitor u_monitor (.*);

    // mode 0 offsets, 1 capture window, 2 status view, 3 memory port
    task automatic drive_cycle(input int mode);
        logic [31:0]            r;
        logic [sw_width-1:0]    sw_next;
        logic [probe_width-1:0] probe_next;
        r = $random(seed);
        sw_next = r[9:0];
        if (mode == 1) sw_next = {6'b0, r[3:0]};
        else if (mode == 2 && sw_next < 16) sw_next[4] = 1'b1;
        probe_next = r[31:13];
        // valid mark about one cycle in twelve
        probe_next[8] = ($unsigned($random(seed)) % 12) == 0;
        sw         <= sw_next;
        probe      <= probe_next;
        update_x   <= ($unsigned($random(seed)) % 8) == 0;
        update_y   <= ($unsigned($random(seed)) % 8) == 0;
        write_done <= (mode == 0) ? 1'b0 : r[12];
        read_en    <= r[11];
        write_addr <= mem_addr_width'($random(seed));
        read_addr  <= mem_addr_width'($random(seed));
    endtask

    task automatic run_test(input string name, input int cycles, input int mode);
        int unsigned checks_before;
        int unsigned errors_before;
        checks_before = check_count;
        errors_before = error_count;
        repeat (cycles) begin
            @(posedge CLOCK_50);
            drive_cycle(mode);
        end
        // let the last compare land
        @(negedge CLOCK_50);
        #1;
        $display("test %-8s %0d checks, %0d errors", name,
                 check_count - checks_before, error_count - errors_before);
    endtask

    initial begin
        sw = '0;
        update_x = 1'b0;
        update_y = 1'b0;
        probe = '0;
        write_done = 1'b0;
        read_en = 1'b0;
        write_addr = '0;
        read_addr = '0;
        wait (delayed_reset === 1'b0);
        run_test("offsets", offset_cycles, 0);
        run_test("capture", capture_cycles, 1);
        run_test("status", status_cycles, 2);
        run_test("port", port_cycles, 3);
        $display("summary: 4 tests, %0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, dut.u_chk.fail_count);
        if (error_count == 0 && dut.u_chk.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog over the summed test lengths
    initial begin
        #((total_cycles + 100) * clk_period);
        $display("timeout: tests did not finish within %0d cycles", total_cycles + 100);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- slm_panel.f
verilog/slm_panel_pkg.sv
verilog/offset_regs.sv
verilog/trace_capture.sv
verilog/panel_control.sv
verilog/slm_panel_top.sv
dv/tb_clock_gen.sv
dv/slm_panel_chk.sv
dv/tb_panel_monitor.sv
dv/tb_slm_panel.sv
